//--- flist.f
+incdir+sim
rtl/execPkg.sv
rtl/rvIsaPkg.sv
rtl/aluUnit.sv
rtl/mulDivUnit.sv
rtl/executeStage.sv
sim/tbExecute.sv

//--- rtl/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  execPkg::xlenT   opA,
    input  execPkg::xlenT   opB,
    input  rvIsaPkg::aluOpT aluOp,
    output execPkg::xlenT   result,
    output execPkg::xlenT   resultWord
);
    import execPkg::*;
    import rvIsaPkg::*;

    logic [$clog2(XLEN)-1:0] shamt;
    logic [4:0]              shamtWord;
    logic [31:0]             wordA;
    logic [31:0]             wordB;
    logic [31:0]             word;

    assign shamt     = opB[$clog2(XLEN)-1:0];
    assign shamtWord = opB[4:0];
    assign wordA     = opA[31:0];
    assign wordB     = opB[31:0];

    //////////////////////////////////////////////////
    // full width.
    //////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            ALU_ADD:  result = opA + opB;
            ALU_SUB:  result = opA - opB;
            ALU_SLL:  result = opA << shamt;
            ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(opA) < $signed(opB)};
            ALU_SLTU: result = {{(XLEN-1){1'b0}}, opA < opB};
            ALU_XOR:  result = opA ^ opB;
            ALU_SRL:  result = opA >> shamt;
            ALU_SRA:  result = xlenT'($signed(opA) >>> shamt);
            ALU_OR:   result = opA | opB;
            ALU_AND:  result = opA & opB;
            default:  result = '0;
        endcase
    end

    //////////////////////////////////////////////////
    // W forms, low 32 bits.
    //////////////////////////////////////////////////

    always_comb begin
        case (aluOp)
            ALU_ADD:  word = wordA + wordB;
            ALU_SUB:  word = wordA - wordB;
            ALU_SLL:  word = wordA << shamtWord;
            ALU_SLT:  word = {31'b0, $signed(wordA) < $signed(wordB)};
            ALU_SLTU: word = {31'b0, wordA < wordB};
            ALU_XOR:  word = wordA ^ wordB;
            ALU_SRL:  word = wordA >> shamtWord;
            ALU_SRA:  word = 32'($signed(wordA) >>> shamtWord);
            ALU_OR:   word = wordA | wordB;
            ALU_AND:  word = wordA & wordB;
            default:  word = '0;
        endcase
    end

    // sign-extend to the full width.
    assign resultWord = {{(XLEN-32){word[31]}}, word};

endmodule

//--- rtl/execPkg.sv
package execPkg;

    // datapath.
    localparam int XLEN      = 64;
    localparam int REG_IDX_W = 5;

    // slots offered by the memory stage after reset.
    localparam int OUT_CREDITS = 2;
    localparam int CREDIT_W    = $clog2(OUT_CREDITS + 1);

    // one iteration per operand bit.
    localparam int MD_STEPS = 64;
    localparam int MD_CNT_W = $clog2(MD_STEPS);

    typedef logic [XLEN-1:0]      xlenT;
    typedef logic [REG_IDX_W-1:0] regIdxT;

endpackage

//--- rtl/executeStage.sv
`timescale 1ns/10ps

module executeStage (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              outCredit,
    input  logic              inValid,
    input  execPkg::xlenT     inPc,
    input  execPkg::xlenT     inRs1,
    input  execPkg::xlenT     inRs2,
    input  execPkg::xlenT     inImm,
    input  execPkg::xlenT     inCsrValue,
    input  rvIsaPkg::srcASelT inSrcA,
    input  rvIsaPkg::srcBSelT inSrcB,
    input  rvIsaPkg::aluOpT   inAluOp,
    input  rvIsaPkg::mulOpT   inMulOp,
    input  logic              inIsMulDiv,
    input  logic              inWordOp,
    input  logic              inIsCompare,
    input  logic              inCmpImm,
    input  rvIsaPkg::flagSelT inFlagSel,
    input  logic              inFlagInv,
    input  rvIsaPkg::csrOpT   inCsrOp,
    input  execPkg::regIdxT   inRd,
    output logic              inCredit,
    output logic              outValid,
    output execPkg::xlenT     outResult,
    output logic              outFlag,
    output logic              outCsrWrite,
    output execPkg::xlenT     outCsrWriteValue,
    output execPkg::regIdxT   outRd,
    output logic              fwdValid,
    output execPkg::regIdxT   fwdRd,
    output execPkg::xlenT     fwdData
);
    import execPkg::*;
    import rvIsaPkg::*;

    logic    holdValidQ;
    xlenT    pcQ;
    xlenT    rs1Q;
    xlenT    rs2Q;
    xlenT    immQ;
    xlenT    csrValQ;
    srcASelT srcAQ;
    srcBSelT srcBQ;
    aluOpT   aluOpQ;
    mulOpT   mulOpQ;
    logic    isMulDivQ;
    logic    wordOpQ;
    logic    isCompareQ;
    logic    cmpImmQ;
    flagSelT flagSelQ;
    logic    flagInvQ;
    csrOpT   csrOpQ;
    regIdxT  rdQ;

    logic                mdIssuedQ;
    logic                mdReadyQ;
    logic [CREDIT_W-1:0] outCntQ;

    xlenT pcPlus4;
    xlenT opA;
    xlenT opB;
    xlenT cmpB;
    xlenT aluResult;
    xlenT aluWord;
    xlenT mdResult;
    xlenT csrWriteValue;
    xlenT resultData;
    logic flagRaw;
    logic flag;
    logic mdStart;
    logic mdBusy;
    logic mdDone;
    logic resultReady;
    logic issue;
    logic leave;

    //////////////////////////////////////////////////
    // hold register.
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (inValid) begin
            pcQ        <= inPc;
            rs1Q       <= inRs1;
            rs2Q       <= inRs2;
            immQ       <= inImm;
            csrValQ    <= inCsrValue;
            srcAQ      <= inSrcA;
            srcBQ      <= inSrcB;
            aluOpQ     <= inAluOp;
            mulOpQ     <= inMulOp;
            isMulDivQ  <= inIsMulDiv;
            wordOpQ    <= inWordOp;
            isCompareQ <= inIsCompare;
            cmpImmQ    <= inCmpImm;
            flagSelQ   <= inFlagSel;
            flagInvQ   <= inFlagInv;
            csrOpQ     <= inCsrOp;
            rdQ        <= inRd;
        end
    end

    assign pcPlus4 = pcQ + xlenT'(4);

    //////////////////////////////////////////////////
    // operands and compute.
    //////////////////////////////////////////////////

    always_comb begin
        case (srcAQ)
            SRC_A_ZERO: opA = '0;
            SRC_A_RS1:  opA = rs1Q;
            SRC_A_PC:   opA = pcQ;
            default:    opA = pcPlus4;
        endcase
        case (srcBQ)
            SRC_B_RS2:   opB = rs2Q;
            SRC_B_IMM:   opB = immQ;
            SRC_B_IMM12: opB = immQ << 12;
            default:     opB = csrValQ;
        endcase
    end

    aluUnit alu (
        .opA        (opA),
        .opB        (opB),
        .aluOp      (aluOpQ),
        .result     (aluResult),
        .resultWord (aluWord)
    );

    // one start per held instruction, flush aborts it.
    assign mdStart = holdValidQ & isMulDivQ & ~mdIssuedQ & ~mdBusy;

    mulDivUnit mulDiv (
        .clk    (clk),
        .rst    (rst),
        .start  (mdStart),
        .abort  (flush),
        .opA    (opA),
        .opB    (opB),
        .mulOp  (mulOpQ),
        .wordOp (wordOpQ),
        .busy   (mdBusy),
        .done   (mdDone),
        .result (mdResult)
    );

    // compare against imm or rs2.
    assign cmpB = cmpImmQ ? immQ : rs2Q;

    always_comb begin
        case (flagSelQ)
            FLAG_LT:  flagRaw = $signed(rs1Q) < $signed(cmpB);
            FLAG_LTU: flagRaw = rs1Q < cmpB;
            FLAG_EQ:  flagRaw = rs1Q == cmpB;
            default:  flagRaw = 1'b0;
        endcase
    end

    assign flag = flagRaw ^ flagInvQ;

    always_comb begin
        case (csrOpQ)
            CSR_RW:  csrWriteValue = rs1Q;
            CSR_RS:  csrWriteValue = csrValQ | rs1Q;
            CSR_RC:  csrWriteValue = csrValQ & ~rs1Q;
            CSR_RWI: csrWriteValue = immQ;
            CSR_RSI: csrWriteValue = csrValQ | immQ;
            CSR_RCI: csrWriteValue = csrValQ & ~immQ;
            default: csrWriteValue = '0;
        endcase
    end

    always_comb begin
        if (isCompareQ) begin
            resultData = {{(XLEN-1){1'b0}}, flag};
        end else if (isMulDivQ) begin
            resultData = mdResult;
        end else if (wordOpQ) begin
            resultData = aluWord;
        end else begin
            resultData = aluResult;
        end
    end

    //////////////////////////////////////////////////
    // flow control and output.
    //////////////////////////////////////////////////

    assign resultReady = holdValidQ & (~isMulDivQ | mdReadyQ | mdDone);
    assign issue       = resultReady & (outCntQ != '0) & ~flush;
    assign leave       = issue | (flush & holdValidQ);

    assign fwdValid = resultReady & (rdQ != '0);
    assign fwdRd    = rdQ;
    assign fwdData  = resultData;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            holdValidQ <= 1'b0;
            mdIssuedQ  <= 1'b0;
            mdReadyQ   <= 1'b0;
            outCntQ    <= CREDIT_W'(OUT_CREDITS);
            outValid   <= 1'b0;
            inCredit   <= 1'b0;
        end else begin
            if (mdStart) begin
                mdIssuedQ <= 1'b1;
            end
            if (mdDone) begin
                mdReadyQ <= 1'b1;
            end
            if (leave) begin
                holdValidQ <= 1'b0;
                mdIssuedQ  <= 1'b0;
                mdReadyQ   <= 1'b0;
            end
            if (inValid) begin
                holdValidQ <= 1'b1;
                mdIssuedQ  <= 1'b0;
                mdReadyQ   <= 1'b0;
            end
            outCntQ  <= outCntQ - CREDIT_W'(issue) + CREDIT_W'(outCredit);
            outValid <= issue;
            inCredit <= leave;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            outResult        <= resultData;
            outFlag          <= flag;
            outCsrWrite      <= (csrOpQ != CSR_NONE);
            outCsrWriteValue <= csrWriteValue;
            outRd            <= rdQ;
        end
    end

endmodule

//--- rtl/mulDivUnit.sv
`timescale 1ns/10ps

module mulDivUnit (
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  logic            abort,
    input  execPkg::xlenT   opA,
    input  execPkg::xlenT   opB,
    input  rvIsaPkg::mulOpT mulOp,
    input  logic            wordOp,
    output logic            busy,
    output logic            done,
    output execPkg::xlenT   result
);
    import execPkg::*;
    import rvIsaPkg::*;

    logic signedA;
    logic signedB;
    logic negA;
    logic negB;
    xlenT extA;
    xlenT extB;

    logic [MD_CNT_W-1:0] stepCnt;
    xlenT                accQ;
    xlenT                lowQ;
    xlenT                magBQ;
    mulOpT               opQ;
    logic                isDivQ;
    logic                wordQ;
    logic                negResQ;
    logic                negRemQ;
    logic                divZeroQ;

    logic [XLEN:0]     mulSum;
    logic [XLEN:0]     divShift;
    logic [XLEN+1:0]   divTrial;
    logic [2*XLEN-1:0] prod;
    xlenT              quotient;
    xlenT              remainder;
    xlenT              full;

    //////////////////////////////////////////////////
    // operand preparation.
    //////////////////////////////////////////////////

    assign signedA = (mulOp == MUL_MULH) || (mulOp == MUL_MULHSU) ||
                     (mulOp == MUL_DIV) || (mulOp == MUL_REM);
    assign signedB = (mulOp == MUL_MULH) || (mulOp == MUL_DIV) || (mulOp == MUL_REM);

    // word forms reduce to 32 bits first.
    assign extA = wordOp ? {{(XLEN-32){signedA & opA[31]}}, opA[31:0]} : opA;
    assign extB = wordOp ? {{(XLEN-32){signedB & opB[31]}}, opB[31:0]} : opB;

    assign negA = signedA & extA[XLEN-1];
    assign negB = signedB & extB[XLEN-1];

    //////////////////////////////////////////////////
    // iteration.
    //////////////////////////////////////////////////

    assign mulSum   = {1'b0, accQ} + {1'b0, (lowQ[0] ? magBQ : '0)};
    assign divShift = {accQ, lowQ[XLEN-1]};
    assign divTrial = {1'b0, divShift} - {2'b0, magBQ};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy    <= 1'b0;
            done    <= 1'b0;
            stepCnt <= '0;
        end else begin
            done <= 1'b0;
            if (abort) begin
                busy <= 1'b0;
            end else if (start) begin
                busy    <= 1'b1;
                stepCnt <= '0;
            end else if (busy) begin
                stepCnt <= stepCnt + 1'b1;
                if (stepCnt == MD_CNT_W'(MD_STEPS - 1)) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            accQ     <= '0;
            lowQ     <= negA ? -extA : extA;
            magBQ    <= negB ? -extB : extB;
            opQ      <= mulOp;
            isDivQ   <= mulOp[2];
            wordQ    <= wordOp;
            negResQ  <= negA ^ negB;
            negRemQ  <= negA;
            divZeroQ <= (extB == '0);
        end else if (busy) begin
            if (isDivQ) begin
                // restoring step, keep the trial only if it did not borrow.
                if (!divTrial[XLEN+1]) begin
                    accQ <= divTrial[XLEN-1:0];
                end else begin
                    accQ <= divShift[XLEN-1:0];
                end
                lowQ <= {lowQ[XLEN-2:0], ~divTrial[XLEN+1]};
            end else begin
                accQ <= mulSum[XLEN:1];
                lowQ <= {mulSum[0], lowQ[XLEN-1:1]};
            end
        end
    end

    //////////////////////////////////////////////////
    // result.
    //////////////////////////////////////////////////

    assign prod      = negResQ ? -{accQ, lowQ} : {accQ, lowQ};
    assign quotient  = divZeroQ ? '1 : (negResQ ? -lowQ : lowQ);
    assign remainder = negRemQ ? -accQ : accQ;

    always_comb begin
        case (opQ)
            MUL_MUL:                         full = prod[XLEN-1:0];
            MUL_MULH, MUL_MULHSU, MUL_MULHU: full = prod[2*XLEN-1:XLEN];
            MUL_DIV, MUL_DIVU:               full = quotient;
            default:                         full = remainder;
        endcase
    end

    assign result = wordQ ? {{(XLEN-32){full[31]}}, full[31:0]} : full;

endmodule

//--- rtl/rvIsaPkg.sv
package rvIsaPkg;

    // operand A source.
    typedef enum logic [1:0] {
        SRC_A_ZERO = 2'd0,
        SRC_A_RS1  = 2'd1,
        SRC_A_PC   = 2'd2,
        SRC_A_PC4  = 2'd3
    } srcASelT;

    // operand B source.
    typedef enum logic [1:0] {
        SRC_B_RS2   = 2'd0,
        SRC_B_IMM   = 2'd1,
        SRC_B_IMM12 = 2'd2,
        SRC_B_CSR   = 2'd3
    } srcBSelT;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } aluOpT;

    // same order as funct3 of the M extension.
    typedef enum logic [2:0] {
        MUL_MUL    = 3'd0,
        MUL_MULH   = 3'd1,
        MUL_MULHSU = 3'd2,
        MUL_MULHU  = 3'd3,
        MUL_DIV    = 3'd4,
        MUL_DIVU   = 3'd5,
        MUL_REM    = 3'd6,
        MUL_REMU   = 3'd7
    } mulOpT;

    typedef enum logic [2:0] {
        CSR_NONE = 3'd0,
        CSR_RW   = 3'd1,
        CSR_RS   = 3'd2,
        CSR_RC   = 3'd3,
        CSR_RWI  = 3'd4,
        CSR_RSI  = 3'd5,
        CSR_RCI  = 3'd6
    } csrOpT;

    typedef enum logic [1:0] {
        FLAG_LT  = 2'd0,
        FLAG_LTU = 2'd1,
        FLAG_EQ  = 2'd2
    } flagSelT;

endpackage

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tbExecute -f flist.f -o simExecute

# a failing run still writes its log, the grep below decides.
./obj_dir/simExecute > sim.log 2>&1 || true
cat sim.log

if grep -qx "=== PASS ===" sim.log; then
    exit 0
else
    exit 1
fi

//--- sim/execRef.svh
`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// galois lfsr, one step per returned bit.
function automatic logic [63:0] randBits(input int n);
    logic [63:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[62:0], lfsrState[0]};
        lfsrState = {1'b0, lfsrState[31:1]} ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
    end
    return v;
endfunction

function automatic logic [63:0] sext32(input logic [31:0] w);
    return {{32{w[31]}}, w};
endfunction

function automatic logic [63:0] aluModel(input logic [63:0] a, input logic [63:0] b,
                                         input aluOpT op, input logic word);
    logic [63:0] r;
    logic [31:0] w;
    case (op)
        ALU_ADD: begin
            r = a + b;
            w = a[31:0] + b[31:0];
        end
        ALU_SUB: begin
            r = a - b;
            w = a[31:0] - b[31:0];
        end
        ALU_SLL: begin
            r = a << b[5:0];
            w = a[31:0] << b[4:0];
        end
        ALU_SLT: begin
            r = {63'b0, $signed(a) < $signed(b)};
            w = {31'b0, $signed(a[31:0]) < $signed(b[31:0])};
        end
        ALU_SLTU: begin
            r = {63'b0, a < b};
            w = {31'b0, a[31:0] < b[31:0]};
        end
        ALU_XOR: begin
            r = a ^ b;
            w = a[31:0] ^ b[31:0];
        end
        ALU_SRL: begin
            r = a >> b[5:0];
            w = a[31:0] >> b[4:0];
        end
        ALU_SRA: begin
            r = $unsigned($signed(a) >>> b[5:0]);
            w = $unsigned($signed(a[31:0]) >>> b[4:0]);
        end
        ALU_OR: begin
            r = a | b;
            w = a[31:0] | b[31:0];
        end
        default: begin
            r = a & b;
            w = a[31:0] & b[31:0];
        end
    endcase
    return word ? sext32(w) : r;
endfunction

function automatic logic [63:0] mulDivModel(input logic [63:0] a, input logic [63:0] b,
                                            input mulOpT op, input logic word);
    logic         sa;
    logic         sb;
    logic [63:0]  x;
    logic [63:0]  y;
    logic [63:0]  q;
    logic [63:0]  rm;
    logic [63:0]  r;
    logic [127:0] p;
    sa = op inside {MUL_MULH, MUL_MULHSU, MUL_DIV, MUL_REM};
    sb = op inside {MUL_MULH, MUL_DIV, MUL_REM};
    x = word ? (sa ? sext32(a[31:0]) : {32'b0, a[31:0]}) : a;
    y = word ? (sb ? sext32(b[31:0]) : {32'b0, b[31:0]}) : b;
    // sign-extended operands give the signed product modulo 2^128.
    p = {{64{sa & x[63]}}, x} * {{64{sb & y[63]}}, y};
    if (y == 64'b0) begin
        q = '1;
        rm = x;
    end else begin
        q = ((sa & x[63]) ? -x : x) / ((sb & y[63]) ? -y : y);
        rm = ((sa & x[63]) ? -x : x) % ((sb & y[63]) ? -y : y);
        if ((sa & x[63]) ^ (sb & y[63])) begin
            q = -q;
        end
        if (sa & x[63]) begin
            rm = -rm;
        end
    end
    case (op)
        MUL_MUL:                         r = p[63:0];
        MUL_MULH, MUL_MULHSU, MUL_MULHU: r = p[127:64];
        MUL_DIV, MUL_DIVU:               r = q;
        default:                         r = rm;
    endcase
    return word ? sext32(r[31:0]) : r;
endfunction

function automatic logic [63:0] csrNewValue(input csrOpT op, input logic [63:0] csr,
                                            input logic [63:0] rs1, input logic [63:0] imm);
    case (op)
        CSR_RW:  return rs1;
        CSR_RS:  return csr | rs1;
        CSR_RC:  return csr & ~rs1;
        CSR_RWI: return imm;
        CSR_RSI: return csr | imm;
        default: return csr & ~imm;
    endcase
endfunction

function automatic logic compareFlag(input flagSelT sel, input logic inv,
                                     input logic [63:0] a, input logic [63:0] b);
    case (sel)
        FLAG_LT:  return ($signed(a) < $signed(b)) ^ inv;
        FLAG_LTU: return (a < b) ^ inv;
        default:  return (a == b) ^ inv;
    endcase
endfunction

`endif

//--- sim/tbExecute.sv
`timescale 1ns/10ps

module tbExecute;
    import execPkg::*;
    import rvIsaPkg::*;

    localparam int NUM_INSTR        = 400;
    localparam int RESET_CYCLES     = 10;
    localparam int MAX_CREDIT_DELAY = 64;
    localparam int TIMEOUT_CYCLES   =
        RESET_CYCLES + NUM_INSTR * (MD_STEPS + MAX_CREDIT_DELAY + 4) + 3 * MAX_CREDIT_DELAY;

    typedef struct packed {
        logic [63:0] result;
        logic        flag;
        logic        csrWrite;
        logic [63:0] csrVal;
        logic [4:0]  rd;
        logic [1:0]  kind;
    } expT;

    logic clk = 1'b0;
    logic rst = 1'b1;
    logic flush;
    logic outCredit = 1'b0;
    logic inValid;
    logic inIsMulDiv;
    logic inWordOp;
    logic inIsCompare;
    logic inCmpImm;
    logic inFlagInv;
    xlenT inPc;
    xlenT inRs1;
    xlenT inRs2;
    xlenT inImm;
    xlenT inCsrValue;
    srcASelT inSrcA;
    srcBSelT inSrcB;
    aluOpT inAluOp;
    mulOpT inMulOp;
    flagSelT inFlagSel;
    csrOpT inCsrOp;
    regIdxT inRd;
    logic inCredit;
    logic outValid;
    logic outFlag;
    logic outCsrWrite;
    logic fwdValid;
    xlenT outResult;
    xlenT outCsrWriteValue;
    xlenT fwdData;
    regIdxT outRd;
    regIdxT fwdRd;

    logic [31:0] lfsrState = 32'h79f0_db3e;
    expT expQ[$];
    int delayQ[$];
    int dsCredits = OUT_CREDITS;
    int sentCount = 0;
    int inCreditCount = 0;
    int cycleCount = 0;
    int retWait = 0;
    logic retActive = 1'b0;
    logic pendingFlushed = 1'b0;
    logic fwdSeen = 1'b0;
    string testNames[4] = '{"alu", "muldiv", "compare", "csr"};

`include "execRef.svh"

    executeStage i_dut (.*);

    always #20 clk = ~clk;

    task automatic failRun(input string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1, "run stopped");
    endtask

    task automatic checkValue(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
        assert (expected === actual) else begin
            $display("Mismatch %s expected %h actual %h", name, expected, actual);
            failRun("wrong value seen at the DUT output");
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus.
    //////////////////////////////////////////////////

    task automatic sendOne(input int idx);
        logic [63:0] r;
        logic [63:0] rs1;
        logic [63:0] rs2;
        logic [63:0] imm;
        logic [63:0] csr;
        logic [63:0] pc;
        logic [63:0] a;
        logic [63:0] b;
        logic [1:0] kind;
        srcASelT srcA;
        srcBSelT srcB;
        aluOpT aluOp;
        mulOpT mulOp;
        logic wordOp;
        regIdxT rd;
        flagSelT flagSel;
        logic flagInv;
        logic cmpImm;
        csrOpT csrOp;
        expT e;
        logic flushNow;
        int flushDelay;
        int waitCnt;
        logic gotCredit;
        @(posedge clk);
        r = randBits(32);
        rs1 = randBits(64);
        rs2 = randBits(64);
        imm = randBits(64);
        csr = randBits(64);
        pc = randBits(64);
        kind = (idx < 64) ? 2'd1 : r[25:24];
        srcA = srcASelT'(r[1:0]);
        srcB = srcBSelT'(r[3:2]);
        aluOp = aluOpT'(r[7:4] % 4'd10);
        mulOp = mulOpT'(r[10:8]);
        wordOp = r[11];
        rd = r[16:12];
        flagSel = flagSelT'(r[18:17] % 2'd3);
        flagInv = r[19];
        cmpImm = r[20];
        csrOp = (kind == 2'd3) ? csrOpT'(r[23:21] % 3'd6 + 3'd1) : CSR_NONE;
        // first block walks every M op, word form and corner operand.
        if (idx < 64) begin
            srcA = SRC_A_RS1;
            srcB = SRC_B_RS2;
            mulOp = mulOpT'(idx[2:0]);
            wordOp = idx[3];
            if (idx[5:4] == 2'd2) begin
                rs2 = '0;
            end else if (idx[5:4] == 2'd3) begin
                // most negative number of the operand width.
                rs1 = idx[3] ? 64'h0000_0000_8000_0000 : 64'h8000_0000_0000_0000;
                rs2 = '1;
            end
        end
        if (kind == 2'd2 && r[26]) begin
            rs2 = rs1;
            imm = rs1;
        end
        a = (srcA == SRC_A_ZERO) ? 64'b0 : (srcA == SRC_A_RS1) ? rs1 :
            (srcA == SRC_A_PC) ? pc : pc + 64'd4;
        b = (srcB == SRC_B_RS2) ? rs2 : (srcB == SRC_B_IMM) ? imm :
            (srcB == SRC_B_IMM12) ? imm << 12 : csr;
        e.kind = kind;
        e.rd = rd;
        e.flag = compareFlag(flagSel, flagInv, rs1, cmpImm ? imm : rs2);
        e.csrWrite = (csrOp != CSR_NONE);
        e.csrVal = e.csrWrite ? csrNewValue(csrOp, csr, rs1, imm) : 64'b0;
        if (kind == 2'd2) begin
            e.result = {63'b0, e.flag};
        end else if (kind == 2'd1) begin
            e.result = mulDivModel(a, b, mulOp, wordOp);
        end else begin
            e.result = aluModel(a, b, aluOp, wordOp);
        end
        flushNow = (idx >= 64) && (r[30:27] == 4'd0);
        flushDelay = (idx >= 64 && kind == 2'd1 && r[29:28] == 2'd1) ? 1 + 4 * r[31:30] : 0;
        inValid <= 1'b1;
        inPc <= pc;
        inRs1 <= rs1;
        inRs2 <= rs2;
        inImm <= imm;
        inCsrValue <= csr;
        inSrcA <= srcA;
        inSrcB <= srcB;
        inAluOp <= aluOp;
        inMulOp <= mulOp;
        inWordOp <= wordOp;
        inRd <= rd;
        inFlagSel <= flagSel;
        inFlagInv <= flagInv;
        inCmpImm <= cmpImm;
        inCsrOp <= csrOp;
        inIsMulDiv <= (kind == 2'd1);
        inIsCompare <= (kind == 2'd2);
        flush <= 1'b0;
        sentCount++;
        pendingFlushed = flushNow || (flushDelay != 0);
        if (!pendingFlushed) begin
            expQ.push_back(e);
        end
        gotCredit = 1'b0;
        waitCnt = 0;
        while (!gotCredit) begin
            @(posedge clk);
            inValid <= 1'b0;
            flush <= (flushNow && waitCnt == 0) || (flushDelay != 0 && waitCnt == flushDelay);
            waitCnt++;
            @(negedge clk);
            gotCredit = inCredit;
        end
    endtask

    // downstream returns each credit after its own delay.
    always @(posedge clk) begin
        outCredit <= 1'b0;
        if (retActive) begin
            if (retWait == 0) begin
                outCredit <= 1'b1;
                retActive = 1'b0;
            end else begin
                retWait--;
            end
        end else if (delayQ.size() > 0) begin
            retWait = delayQ.pop_front();
            retActive = 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // compare.
    //////////////////////////////////////////////////

    always @(negedge clk) begin
        expT e;
        logic [63:0] r;
        if (!rst) begin
            if (outValid) begin
                assert (dsCredits > 0) else failRun("outValid pulsed with no output credit held");
                dsCredits--;
                r = randBits(6);
                delayQ.push_back(r[5] ? int'(r[5:0]) : int'(r[2:0]));
                assert (expQ.size() > 0) else failRun("a result came out with none pending");
                e = expQ.pop_front();
                checkValue({testNames[e.kind], " result"}, e.result, outResult);
                checkValue({testNames[e.kind], " flag"}, {63'b0, e.flag}, {63'b0, outFlag});
                checkValue({testNames[e.kind], " csr write"}, {63'b0, e.csrWrite},
                           {63'b0, outCsrWrite});
                if (e.csrWrite) begin
                    checkValue({testNames[e.kind], " csr value"}, e.csrVal, outCsrWriteValue);
                end
                checkValue({testNames[e.kind], " rd"}, {59'b0, e.rd}, {59'b0, outRd});
                if (e.rd != 5'd0) begin
                    assert (fwdSeen) else failRun("fwdValid stayed low for a ready result");
                end
            end
            if (outCredit) begin
                dsCredits++;
            end
            if (inCredit) begin
                inCreditCount++;
            end
            if (fwdValid && !pendingFlushed) begin
                assert (expQ.size() > 0 && fwdRd != 5'd0)
                    else failRun("fwdValid high with rd zero or no instruction pending");
                checkValue("forward rd", {59'b0, expQ[0].rd}, {59'b0, fwdRd});
                checkValue("forward data", expQ[0].result, fwdData);
            end
            fwdSeen = fwdValid;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        assert (cycleCount < TIMEOUT_CYCLES) else failRun("timeout, the DUT stopped making progress");
    end

    initial begin
        flush = 1'b0;
        inValid = 1'b0;
        inPc = '0;
        inRs1 = '0;
        inRs2 = '0;
        inImm = '0;
        inCsrValue = '0;
        inSrcA = SRC_A_ZERO;
        inSrcB = SRC_B_RS2;
        inAluOp = ALU_ADD;
        inMulOp = MUL_MUL;
        inIsMulDiv = 1'b0;
        inWordOp = 1'b0;
        inIsCompare = 1'b0;
        inCmpImm = 1'b0;
        inFlagSel = FLAG_LT;
        inFlagInv = 1'b0;
        inCsrOp = CSR_NONE;
        inRd = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int i = 0; i < NUM_INSTR; i++) begin
            sendOne(i);
        end
        // let outstanding credits come home.
        repeat (3 * MAX_CREDIT_DELAY) @(posedge clk);
        assert (inCreditCount == sentCount)
            else failRun("inCredit pulses differ from instructions sent");
        assert (expQ.size() == 0) else failRun("some results never reached the output");
        assert (dsCredits == OUT_CREDITS) else failRun("output credits were not all returned");
        $display("=== PASS ===");
        $finish;
    end

endmodule
